// ==== arm_dp_core.f ====
arm_dp_pkg.sv
alu_if.sv
shifter_if.sv
barrel_shifter.sv
alu.sv
dp_decoder.sv
reg_file.sv
arm_dp_core.sv
tb_arm_dp_core.sv

// ==== Makefile ====
SRCS := $(wildcard *.sv)

obj_dir/Vtb_arm_dp_core: $(SRCS) arm_dp_core.f
	verilator --binary --timing -j 0 --top-module tb_arm_dp_core -f arm_dp_core.f

.PHONY: run clean

run: obj_dir/Vtb_arm_dp_core
	./obj_dir/Vtb_arm_dp_core

clean:
	rm -rf obj_dir

// ==== tb_arm_dp_core.sv ====
module tb_arm_dp_core;

    typedef struct packed {
        logic [31:0]        data;
        arm_dp_pkg::flags_t flags;
        logic [3:0]         rd;
        logic               wrote;
        logic               skipped;
        logic               check_data;
        logic [31:0]        due;
    } exp_t;

    logic               clk;
    logic               rst_n;
    logic               instr_valid;
    logic [31:0]        instr;
    logic               result_valid;
    logic [3:0]         result_rd;
    logic [31:0]        result_data;
    arm_dp_pkg::flags_t result_flags;
    logic               result_wrote;
    logic               result_skipped;

    logic [31:0]        mregs [16];  // register mirror.
    arm_dp_pkg::flags_t mflags;
    exp_t               expq [$];
    logic [31:0]        seed = 32'h8eb0;
    logic [31:0]        cycle = 0;

    arm_dp_core #(.DATA_W(32), .REG_CNT(16)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flags(input arm_dp_pkg::flags_t got, input arm_dp_pkg::flags_t exp);
        if (got !== exp) fail_run($sformatf("CHECK FAILED result_flags got %h expected %h", got, exp));
    endtask

    task automatic check_ctl(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    // ********************
    // reference model
    // ********************
    function automatic logic cond_ok(input logic [3:0] cond, input arm_dp_pkg::flags_t f);
        case (cond)
            4'd0:    return f.z;
            4'd1:    return !f.z;
            4'd2:    return f.c;
            4'd3:    return !f.c;
            4'd4:    return f.n;
            4'd5:    return !f.n;
            4'd6:    return f.v;
            4'd7:    return !f.v;
            4'd8:    return f.c && !f.z;
            4'd9:    return !f.c || f.z;
            4'd10:   return f.n == f.v;
            4'd11:   return f.n != f.v;
            4'd12:   return !f.z && (f.n == f.v);
            4'd13:   return f.z || (f.n != f.v);
            4'd14:   return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] operand2(input logic [31:0] ins, input logic [31:0] rm,
                                             input logic cin, output logic cout);
        int          r;
        int          amt;
        logic [31:0] v;
        if (ins[25]) begin
            r = 2 * int'(ins[11:8]);
            v = {24'b0, ins[7:0]};
            cout = cin;
            if (r != 0) begin
                v = (v >> r) | (v << (32 - r));
                cout = v[31];
            end
            return v;
        end
        amt = int'(ins[11:7]);
        case (ins[6:5])
            2'b00: begin
                cout = (amt == 0) ? cin : rm[32-amt];
                return rm << amt;
            end
            2'b01: begin
                cout = (amt == 0) ? rm[31] : rm[amt-1];
                return (amt == 0) ? 32'h0 : rm >> amt;
            end
            2'b10: begin
                cout = (amt == 0) ? rm[31] : rm[amt-1];
                return (amt == 0) ? {32{rm[31]}} : 32'($signed(rm) >>> amt);
            end
            default: begin
                cout = (amt == 0) ? rm[0] : rm[amt-1];
                return (amt == 0) ? {cin, rm[31:1]} : (rm >> amt) | (rm << (32 - amt));
            end
        endcase
    endfunction

    // x + y + cin, or x - y - borrow when sub is set.
    function automatic logic [31:0] arith(input logic [31:0] x, input logic [31:0] y,
                                          input logic cin, input logic sub,
                                          output logic c, output logic v);
        longint us;
        longint ss;
        if (sub) begin
            us = longint'(x) - longint'(y) - longint'(!cin);
            ss = longint'($signed(x)) - longint'($signed(y)) - longint'(!cin);
            c  = (us >= 0);
        end else begin
            us = longint'(x) + longint'(y) + longint'(cin);
            ss = longint'($signed(x)) + longint'($signed(y)) + longint'(cin);
            c  = us[32];
        end
        v = (ss != longint'($signed(us[31:0])));
        return us[31:0];
    endfunction

    task automatic predict(input logic [31:0] ins, output exp_t e);
        logic [3:0]         op;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        res;
        logic               c;
        logic               v;
        logic               pass;
        arm_dp_pkg::flags_t nf;
        op   = ins[24:21];
        pass = cond_ok(ins[31:28], mflags);
        a    = mregs[ins[19:16]];
        b    = operand2(ins, mregs[ins[3:0]], mflags.c, c);
        v    = mflags.v;  // logical ops keep V.
        case (op)
            4'h0, 4'h8: res = a & b;
            4'h1, 4'h9: res = a ^ b;
            4'h2, 4'ha: res = arith(a, b, 1'b1, 1'b1, c, v);
            4'h3:       res = arith(b, a, 1'b1, 1'b1, c, v);
            4'h4, 4'hb: res = arith(a, b, 1'b0, 1'b0, c, v);
            4'h5:       res = arith(a, b, mflags.c, 1'b0, c, v);
            4'h6:       res = arith(a, b, mflags.c, 1'b1, c, v);
            4'h7:       res = arith(b, a, mflags.c, 1'b1, c, v);
            4'hc:       res = a | b;
            4'hd:       res = b;
            4'he:       res = a & ~b;
            default:    res = ~b;
        endcase
        nf           = '{n: res[31], z: (res == 0), c: c, v: v};
        e.data       = res;
        e.rd         = ins[15:12];
        e.skipped    = !pass;
        e.wrote      = pass && (op[3:2] != 2'b10);
        e.check_data = pass;
        e.flags      = (pass && ins[20]) ? nf : mflags;
        e.due        = '0;
        if (e.wrote) mregs[ins[15:12]] = res;
        mflags = e.flags;
    endtask

    // ********************
    // stimulus helpers
    // ********************
    function automatic logic [31:0] dp(input logic [3:0] cond, input logic [3:0] op,
                                       input logic s, input logic [3:0] rn, input logic [3:0] rd,
                                       input logic imm, input logic [11:0] op2);
        return {cond, 2'b00, imm, op, s, rn, rd, op2};
    endfunction

    function automatic logic [11:0] sreg(input logic [4:0] amt, input logic [1:0] ty,
                                         input logic [3:0] rm);
        return {amt, ty, 1'b0, rm};
    endfunction

    task automatic issue(input logic [31:0] ins);
        exp_t e;
        @(posedge clk);
        instr       <= ins;
        instr_valid <= 1'b1;
        predict(ins, e);
        e.due = cycle + 2;  // result shows one edge after acceptance.
        expq.push_back(e);
    endtask

    task automatic idle();
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    // random register-form or immediate-form operand 2.
    function automatic logic [11:0] rand_op2(input logic [31:0] r);
        return sreg(r[15] ? 5'd0 : r[14:10], r[9:8], r[27:24]);
    endfunction

    // ********************
    // compare process
    // ********************
    initial begin
        exp_t e;
        forever begin
            @(negedge clk);
            if (result_valid === 1'b1) begin
                if (expq.size() == 0) begin
                    fail_run("result_valid went high with no instruction outstanding");
                end else begin
                    e = expq.pop_front();
                    check_ctl("result_rd", result_rd, e.rd);
                    check_ctl("result_wrote", {3'b0, result_wrote}, {3'b0, e.wrote});
                    check_ctl("result_skipped", {3'b0, result_skipped}, {3'b0, e.skipped});
                    check_flags(result_flags, e.flags);
                    if (e.check_data) check_data("result_data", result_data, e.data);
                end
            end else if (expq.size() != 0 && cycle >= expq[0].due) begin
                fail_run("result_valid did not rise one cycle after an instruction was issued");
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [3:0]  op;
        int          n;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        mflags      = '0;
        for (int k = 0; k < 16; k++) mregs[k] = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_ctl("result_valid", {3'b0, result_valid}, 4'h0);

        // every rotate value, then boundary operands in r1 to r5.
        for (int k = 0; k < 16; k++) begin
            r = next_rand();
            issue(dp(4'he, 4'hd, 1'b0, 4'h0, 4'(k), 1'b1, {4'(k), r[7:0]}));
        end
        issue(dp(4'he, 4'hd, 1'b0, 4'h0, 4'h1, 1'b1, 12'h102));
        issue(dp(4'he, 4'hf, 1'b0, 4'h0, 4'h2, 1'b1, 12'h102));
        issue(dp(4'he, 4'hf, 1'b0, 4'h0, 4'h3, 1'b1, 12'h000));
        issue(dp(4'he, 4'hd, 1'b0, 4'h0, 4'h4, 1'b1, 12'h000));
        issue(dp(4'he, 4'hd, 1'b0, 4'h0, 4'h5, 1'b1, 12'h001));
        issue(dp(4'he, 4'ha, 1'b1, 4'h1, 4'h0, 1'b0, sreg(5'd0, 2'b00, 4'h5)));  // V set.

        // logical ops with S, rd kept in r8 to r15.
        for (int k = 0; k < 50; k++) begin
            r = next_rand();
            case (r[30:28] % 5)
                0:       op = 4'h0;
                1:       op = 4'h1;
                2:       op = 4'hc;
                3:       op = 4'he;
                default: op = 4'hf;
            endcase
            issue(dp(4'he, op, 1'b1, r[19:16], {1'b1, r[22:20]}, 1'b0, rand_op2(r)));
        end

        for (int k = 0; k < 60; k++) begin
            r  = next_rand();
            op = 4'h2 + 4'(r[30:28] % 6);
            if (r[31]) begin
                r[18:16] = 3'd1 + {1'b0, r[21:20]} + {2'b0, r[4]};
                r[26:24] = 3'd1 + {1'b0, r[13:12]} + {2'b0, r[5]};
                r[19]    = 1'b0;
                r[27]    = 1'b0;
            end
            issue(dp(4'he, op, 1'b1, r[19:16], {1'b1, r[22:20]}, r[7] & r[6], rand_op2(r)));
        end

        // compares, then a MOV of the compare's rd field.
        for (int k = 0; k < 16; k++) begin
            r  = next_rand();
            op = 4'h8 + 4'(k % 4);
            issue(dp(4'he, op, 1'b1, r[19:16], r[23:20], 1'b0, rand_op2(r)));
            issue(dp(4'he, 4'hd, 1'b0, 4'h0, r[23:20], 1'b0, sreg(5'd0, 2'b00, r[23:20])));
        end

        for (int k = 0; k < 40; k++) begin
            r = next_rand();
            issue(dp(4'he, 4'ha, 1'b1, r[19:16], 4'h0, 1'b0, sreg(5'd0, 2'b00, r[27:24])));
            r = next_rand();
            issue(dp(4'(r[31:28] % 15), r[3:0] ^ r[7:4], r[8], r[19:16], r[23:20], 1'b0,
                     rand_op2(r)));
        end

        idle();
        idle();
        for (int k = 0; k < 8; k++) begin  // dependent chain.
            issue(dp(4'he, 4'h4, 1'b1, 4'h7, 4'h7, 1'b1, 12'h003));
        end
        issue(dp(4'he, 4'h4, 1'b0, 4'h7, 4'h8, 1'b0, sreg(5'd1, 2'b00, 4'h7)));
        issue(dp(4'he, 4'h2, 1'b1, 4'h8, 4'h8, 1'b0, sreg(5'd0, 2'b00, 4'h7)));
        issue(dp(4'he, 4'ha, 1'b1, 4'h3, 4'h0, 1'b0, sreg(5'd0, 2'b00, 4'h5)));
        issue(dp(4'he, 4'h5, 1'b1, 4'h8, 4'h9, 1'b0, sreg(5'd0, 2'b00, 4'h8)));
        idle();

        n = 0;
        while (expq.size() != 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (expq.size() != 0) begin
            fail_run("results still outstanding at the end of the run");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== arm_dp_core.sv ====
module arm_dp_core #(
    parameter int DATA_W  = 32,
    parameter int REG_CNT = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       instr_valid,
    input  logic [31:0]                instr,
    output logic                       result_valid,
    output logic [$clog2(REG_CNT)-1:0] result_rd,
    output logic [DATA_W-1:0]          result_data,
    output arm_dp_pkg::flags_t         result_flags,
    output logic                       result_wrote,
    output logic                       result_skipped
);

    arm_dp_pkg::flags_t flags;
    logic               taken;

    alu_if #(.DATA_W(DATA_W), .REG_CNT(REG_CNT)) alu_bus ();
    shifter_if #(.DATA_W(DATA_W)) sh_bus ();

    // ********************
    // datapath
    // ********************
    dp_decoder u_decoder (
        .instr       (instr),
        .instr_valid (instr_valid),
        .flags       (flags),
        .bus         (alu_bus),
        .sh          (sh_bus),
        .taken       (taken)
    );

    reg_file #(.DATA_W(DATA_W), .REG_CNT(REG_CNT)) u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (alu_bus),
        .rm_val (sh_bus.rm_val),  // second read port feeds the shifter.
        .flags  (flags)
    );

    barrel_shifter #(.DATA_W(DATA_W)) u_shifter (
        .sh (sh_bus)
    );

    alu #(.DATA_W(DATA_W)) u_alu (
        .bus         (alu_bus),
        .shifter_bus (sh_bus)
    );

    // ********************
    // result outputs
    // ********************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid   <= 1'b0;
            result_wrote   <= 1'b0;
            result_skipped <= 1'b0;
        end else begin
            result_valid   <= instr_valid;
            result_wrote   <= alu_bus.write_en;
            result_skipped <= instr_valid && !taken;
        end
    end

    // flags as they stand after this instruction.
    always_ff @(posedge clk) begin
        result_rd    <= alu_bus.rd;
        result_data  <= alu_bus.result;
        result_flags <= alu_bus.set_flags ? alu_bus.flags_out : flags;
    end

endmodule

// ==== reg_file.sv ====
module reg_file #(
    parameter int DATA_W  = 32,
    parameter int REG_CNT = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    alu_if.regs_side            bus,
    output logic [DATA_W-1:0]   rm_val,
    output arm_dp_pkg::flags_t  flags
);

    logic [DATA_W-1:0]  regs [REG_CNT];
    arm_dp_pkg::flags_t nzcv;

    // read ports.
    assign bus.op_a = regs[bus.rn];
    assign rm_val   = regs[bus.rm];
    assign flags    = nzcv;

    // ********************
    // writeback
    // ********************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (bus.write_en) begin
            regs[bus.rd] <= bus.result;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            nzcv <= '0;
        end else if (bus.set_flags) begin
            nzcv <= bus.flags_out;
        end
    end

endmodule

// ==== dp_decoder.sv ====
module dp_decoder (
    input  logic [31:0]          instr,
    input  logic                 instr_valid,
    input  arm_dp_pkg::flags_t   flags,
    alu_if.ctrl_side             bus,
    shifter_if.ctrl_side         sh,
    output logic                 taken
);

    arm_dp_pkg::cond_e   cond;
    arm_dp_pkg::alu_op_e opcode;
    logic                imm_bit;
    logic                s_bit;
    logic                pass;

    // ********************
    // field split
    // ********************
    assign cond    = arm_dp_pkg::cond_e'(instr[31:28]);
    assign imm_bit = instr[25];
    assign opcode  = arm_dp_pkg::alu_op_e'(instr[24:21]);
    assign s_bit   = instr[20];

    assign pass  = arm_dp_pkg::cond_pass(cond, flags);
    assign taken = pass;

    // register numbers.
    assign bus.rn = instr[19:16];
    assign bus.rd = instr[15:12];
    assign bus.rm = instr[3:0];

    assign bus.alu_op   = opcode;
    assign bus.carry_in = flags.c;
    assign bus.v_in     = flags.v;

    // compares leave the register file alone.
    assign bus.write_en  = instr_valid && pass && !arm_dp_pkg::is_compare(opcode);
    assign bus.set_flags = instr_valid && pass && s_bit;

    // ********************
    // operand 2
    // ********************
    assign sh.imm_form     = imm_bit;
    assign sh.rot          = instr[11:8];
    assign sh.imm8         = instr[7:0];
    assign sh.shift_amount = instr[11:7];
    assign sh.shift_type   = arm_dp_pkg::shift_type_e'(instr[6:5]);  // bit 4 is ignored.
    assign sh.c_in         = flags.c;

endmodule

// ==== alu.sv ====
module alu #(
    parameter int DATA_W = 32
) (
    alu_if.ALU_side     bus,
    shifter_if.ALU_side shifter_bus
);

    logic [DATA_W-1:0] add_x;
    logic [DATA_W-1:0] add_y;
    logic              add_cin;
    logic              arith;
    logic [DATA_W-1:0] logic_res;
    logic [DATA_W:0]   sum;
    logic [DATA_W-1:0] res;

    // ********************
    // operand selection
    // ********************
    // subtracts run as x + ~y + cin so the adder carry is already NOT borrow.
    always_comb begin
        add_x     = bus.op_a;
        add_y     = shifter_bus.op_b;
        add_cin   = 1'b0;
        arith     = 1'b1;
        logic_res = '0;
        case (bus.alu_op)
            arm_dp_pkg::ALU_OP_ADD, arm_dp_pkg::ALU_OP_CMP_NEG: begin
                add_cin = 1'b0;
            end
            arm_dp_pkg::ALU_OP_ADC: begin
                add_cin = bus.carry_in;
            end
            arm_dp_pkg::ALU_OP_SUB, arm_dp_pkg::ALU_OP_CMP: begin
                add_y   = ~shifter_bus.op_b;
                add_cin = 1'b1;
            end
            arm_dp_pkg::ALU_OP_SBC: begin
                add_y   = ~shifter_bus.op_b;
                add_cin = bus.carry_in;
            end
            arm_dp_pkg::ALU_OP_SUB_REVERSED: begin
                add_x   = shifter_bus.op_b;
                add_y   = ~bus.op_a;
                add_cin = 1'b1;
            end
            arm_dp_pkg::ALU_OP_RSC: begin
                add_x   = shifter_bus.op_b;
                add_y   = ~bus.op_a;
                add_cin = bus.carry_in;
            end
            arm_dp_pkg::ALU_OP_AND, arm_dp_pkg::ALU_OP_TEST: begin
                arith     = 1'b0;
                logic_res = bus.op_a & shifter_bus.op_b;
            end
            arm_dp_pkg::ALU_OP_XOR, arm_dp_pkg::ALU_OP_TEST_EXCLUSIVE: begin
                arith     = 1'b0;
                logic_res = bus.op_a ^ shifter_bus.op_b;
            end
            arm_dp_pkg::ALU_OP_OR: begin
                arith     = 1'b0;
                logic_res = bus.op_a | shifter_bus.op_b;
            end
            arm_dp_pkg::ALU_OP_BIT_CLEAR: begin
                arith     = 1'b0;
                logic_res = bus.op_a & ~shifter_bus.op_b;
            end
            arm_dp_pkg::ALU_OP_MOV: begin
                arith     = 1'b0;
                logic_res = shifter_bus.op_b;
            end
            default: begin  // MVN.
                arith     = 1'b0;
                logic_res = ~shifter_bus.op_b;
            end
        endcase
    end

    assign sum = {1'b0, add_x} + {1'b0, add_y} + {{DATA_W{1'b0}}, add_cin};
    assign res = arith ? sum[DATA_W-1:0] : logic_res;

    // ********************
    // result and flags
    // ********************
    always_comb begin
        bus.result      = res;
        bus.flags_out.n = res[DATA_W-1];
        bus.flags_out.z = (res == '0);
        if (arith) begin
            bus.flags_out.c = sum[DATA_W];
            bus.flags_out.v = ~(add_x[DATA_W-1] ^ add_y[DATA_W-1]) & (add_x[DATA_W-1] ^ res[DATA_W-1]);
        end else begin
            bus.flags_out.c = shifter_bus.shifter_carry;  // carry from operand 2.
            bus.flags_out.v = bus.v_in;
        end
    end

endmodule

// ==== barrel_shifter.sv ====
module barrel_shifter #(
    parameter int DATA_W = 32
) (
    shifter_if.shifter_side sh
);

    localparam int SH_W = $clog2(DATA_W);

    logic [DATA_W-1:0]   imm_ext;
    logic [SH_W-1:0]     imm_rot;
    logic [2*DATA_W-1:0] imm_dbl;
    logic [DATA_W-1:0]   imm_val;
    logic                imm_c;

    logic [DATA_W:0]     lsl_w;  // {carry, value}.
    logic [DATA_W:0]     lsr_w;  // {value, carry}.
    logic [DATA_W:0]     asr_w;
    logic [2*DATA_W-1:0] ror_w;
    logic [DATA_W-1:0]   reg_val;
    logic                reg_c;

    // ********************
    // rotated immediate
    // ********************
    assign imm_ext = {{(DATA_W-8){1'b0}}, sh.imm8};
    assign imm_rot = {sh.rot, 1'b0};
    assign imm_dbl = {imm_ext, imm_ext} >> imm_rot;
    assign imm_val = imm_dbl[DATA_W-1:0];
    assign imm_c   = (sh.rot != 4'h0) ? imm_val[DATA_W-1] : sh.c_in;

    // ********************
    // shifted register
    // ********************
    assign lsl_w = {1'b0, sh.rm_val} << sh.shift_amount;
    assign lsr_w = {sh.rm_val, 1'b0} >> sh.shift_amount;
    assign asr_w = $unsigned($signed({sh.rm_val, 1'b0}) >>> sh.shift_amount);
    assign ror_w = {sh.rm_val, sh.rm_val} >> sh.shift_amount;

    always_comb begin
        reg_val = sh.rm_val;
        reg_c   = sh.c_in;
        case (sh.shift_type)
            arm_dp_pkg::LSL: begin
                if (sh.shift_amount != '0) begin
                    {reg_c, reg_val} = lsl_w;
                end
            end
            arm_dp_pkg::LSR: begin
                if (sh.shift_amount == '0) begin  // LSR #32.
                    reg_val = '0;
                    reg_c   = sh.rm_val[DATA_W-1];
                end else begin
                    {reg_val, reg_c} = lsr_w;
                end
            end
            arm_dp_pkg::ASR: begin
                if (sh.shift_amount == '0) begin  // ASR #32.
                    reg_val = {DATA_W{sh.rm_val[DATA_W-1]}};
                    reg_c   = sh.rm_val[DATA_W-1];
                end else begin
                    {reg_val, reg_c} = asr_w;
                end
            end
            default: begin
                if (sh.shift_amount == '0) begin  // RRX.
                    reg_val = {sh.c_in, sh.rm_val[DATA_W-1:1]};
                    reg_c   = sh.rm_val[0];
                end else begin
                    reg_val = ror_w[DATA_W-1:0];
                    reg_c   = ror_w[DATA_W-1];
                end
            end
        endcase
    end

    assign sh.op_b          = sh.imm_form ? imm_val : reg_val;
    assign sh.shifter_carry = sh.imm_form ? imm_c : reg_c;

endmodule

// ==== shifter_if.sv ====
interface shifter_if #(
    parameter int DATA_W = 32
);
    localparam int SH_W = $clog2(DATA_W);

    arm_dp_pkg::shift_type_e shift_type;
    logic [SH_W-1:0]         shift_amount;
    logic                    imm_form;
    logic [7:0]              imm8;
    logic [3:0]              rot;  // rotate right by twice this.
    logic [DATA_W-1:0]       rm_val;
    logic                    c_in;
    logic [DATA_W-1:0]       op_b;
    logic                    shifter_carry;

    modport shifter_side (
        input  shift_type, shift_amount, imm_form, imm8, rot, rm_val, c_in,
        output op_b, shifter_carry
    );
    modport ALU_side (input op_b, shifter_carry);
    modport ctrl_side (output shift_type, shift_amount, imm_form, imm8, rot, c_in);

endinterface

// ==== alu_if.sv ====
interface alu_if #(
    parameter int DATA_W  = 32,
    parameter int REG_CNT = 16
);
    localparam int REG_W = $clog2(REG_CNT);

    arm_dp_pkg::alu_op_e alu_op;
    logic [REG_W-1:0]    rn;
    logic [REG_W-1:0]    rm;
    logic [REG_W-1:0]    rd;
    logic                set_flags;
    logic                write_en;
    logic                carry_in;
    logic                v_in;  // current V, kept by logical ops.
    logic [DATA_W-1:0]   op_a;
    logic [DATA_W-1:0]   result;
    arm_dp_pkg::flags_t  flags_out;

    modport ALU_side (input alu_op, op_a, carry_in, v_in, output result, flags_out);
    modport ctrl_side (output alu_op, rn, rm, rd, set_flags, write_en, carry_in, v_in);
    modport regs_side (
        input  rn, rm, rd, write_en, set_flags, result, flags_out,
        output op_a
    );

endinterface

// ==== arm_dp_pkg.sv ====
package arm_dp_pkg;

    // data-processing opcodes in ARM encoding order.
    typedef enum logic [3:0] {
        ALU_OP_AND            = 4'h0,
        ALU_OP_XOR            = 4'h1,
        ALU_OP_SUB            = 4'h2,
        ALU_OP_SUB_REVERSED   = 4'h3,
        ALU_OP_ADD            = 4'h4,
        ALU_OP_ADC            = 4'h5,
        ALU_OP_SBC            = 4'h6,
        ALU_OP_RSC            = 4'h7,
        ALU_OP_TEST           = 4'h8,
        ALU_OP_TEST_EXCLUSIVE = 4'h9,
        ALU_OP_CMP            = 4'ha,
        ALU_OP_CMP_NEG        = 4'hb,
        ALU_OP_OR             = 4'hc,
        ALU_OP_MOV            = 4'hd,
        ALU_OP_BIT_CLEAR      = 4'he,
        ALU_OP_NOT            = 4'hf
    } alu_op_e;

    typedef enum logic [1:0] {
        LSL = 2'b00,
        LSR = 2'b01,
        ASR = 2'b10,
        ROR = 2'b11  // amount 0 selects RRX.
    } shift_type_e;

    // 4'hf (NV) has no entry and never executes.
    typedef enum logic [3:0] {
        EQ, NE, CS, CC, MI, PL, VS, VC, HI, LS, GE, LT, GT, LE, AL
    } cond_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    function automatic logic cond_pass(input cond_e cond, input flags_t f);
        case (cond)
            EQ: return f.z;
            NE: return !f.z;
            CS: return f.c;
            CC: return !f.c;
            MI: return f.n;
            PL: return !f.n;
            VS: return f.v;
            VC: return !f.v;
            HI: return f.c && !f.z;
            LS: return !f.c || f.z;
            GE: return f.n == f.v;
            LT: return f.n != f.v;
            GT: return !f.z && (f.n == f.v);
            LE: return f.z || (f.n != f.v);
            AL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // compares update flags only.
    function automatic logic is_compare(input alu_op_e op);
        return op inside {ALU_OP_TEST, ALU_OP_TEST_EXCLUSIVE, ALU_OP_CMP, ALU_OP_CMP_NEG};
    endfunction

endpackage
